/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vga_subsystem
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
hdl/video_pkg.sv
hdl/fb_pkg.sv
hdl/counter.sv
hdl/latency.sv
hdl/vga.sv
hdl/fb_arbiter.sv
hdl/frame_buffer.sv
hdl/host_pixel_writer.sv
hdl/vga_subsystem.sv
verification/tb_vga_subsystem.sv

/* hdl/counter.sv */
module counter #(
    parameter int NUM_BITS = 11
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                enable,
    input  logic [NUM_BITS-1:0] last,
    output logic [NUM_BITS-1:0] count
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (enable) begin
            // wrap after the terminal value
            if (count == last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    a_count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= last
    );

endmodule

/* hdl/fb_arbiter.sv */
module fb_arbiter #(
    parameter int FB_ADDR_BITS = 19,
    parameter int DATA_BITS    = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    scan_req,
    input  logic [FB_ADDR_BITS-1:0] scan_addr,
    input  logic                    host_req,
    input  logic [FB_ADDR_BITS-1:0] host_addr,
    input  logic [DATA_BITS-1:0]    host_data,
    output fb_pkg::fb_owner_e       grant,
    output logic                    mem_we,
    output logic [FB_ADDR_BITS-1:0] mem_addr,
    output logic [DATA_BITS-1:0]    mem_wdata
);
    import fb_pkg::*;

    // scan side always wins
    always_comb begin
        if (scan_req) begin
            grant = OWN_SCAN;
        end else if (host_req) begin
            grant = OWN_HOST;
        end else begin
            grant = OWN_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_we <= 1'b0;
        end else begin
            mem_we <= grant == OWN_HOST;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr  <= (grant == OWN_HOST) ? host_addr : scan_addr;
        mem_wdata <= host_data;
    end

    a_scan_never_blocked: assert property (
        @(posedge clk) disable iff (!rst_n)
        scan_req |-> grant != OWN_HOST
    );

    a_write_follows_host_grant: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_we |-> $past(grant == OWN_HOST)
    );

endmodule

/* hdl/fb_pkg.sv */
package fb_pkg;

    // who drives the pixel memory port in a given cycle
    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_SCAN,
        OWN_HOST
    } fb_owner_e;

    // host writer FSM
    typedef enum logic {
        WR_IDLE,
        WR_PENDING
    } wr_state_e;

endpackage

/* hdl/frame_buffer.sv */
module frame_buffer #(
    parameter int H_VIS_AREA_PXL = 800,
    parameter int V_VIS_AREA_PXL = 600,
    parameter int CHANNEL_BITS   = 2,
    parameter int FB_ADDR_BITS   = 19
) (
    input  logic                                            clk,
    input  logic                                            mem_we,
    input  logic [FB_ADDR_BITS-1:0]                         mem_addr,
    input  logic [video_pkg::NUM_CHANNELS*CHANNEL_BITS-1:0] mem_wdata,
    output logic [video_pkg::NUM_CHANNELS*CHANNEL_BITS-1:0] mem_rdata
);
    import video_pkg::*;

    localparam int DEPTH     = H_VIS_AREA_PXL * V_VIS_AREA_PXL;
    localparam int WORD_BITS = NUM_CHANNELS * CHANNEL_BITS;

    logic [WORD_BITS-1:0] mem [DEPTH];

    // read and write share the one address
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        mem_rdata <= mem[mem_addr];
    end

endmodule

/* hdl/host_pixel_writer.sv */
module host_pixel_writer #(
    parameter int H_VIS_AREA_PXL = 800,
    parameter int V_VIS_AREA_PXL = 600,
    parameter int H_NUM_BITS     = 11,
    parameter int V_NUM_BITS     = 10,
    parameter int CHANNEL_BITS   = 2,
    parameter int FB_ADDR_BITS   = 19
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            wr_strobe,
    input  logic [H_NUM_BITS-1:0]                           wr_x,
    input  logic [V_NUM_BITS-1:0]                           wr_y,
    input  logic [video_pkg::NUM_CHANNELS*CHANNEL_BITS-1:0] wr_color,
    input  fb_pkg::fb_owner_e                               grant,
    output logic                                            busy,
    output logic                                            wr_reject,
    output logic                                            host_req,
    output logic [FB_ADDR_BITS-1:0]                         host_addr,
    output logic [video_pkg::NUM_CHANNELS*CHANNEL_BITS-1:0] host_data
);
    import fb_pkg::*;

    wr_state_e state;
    logic      in_range;
    logic      accept;

    assign in_range = (wr_x < H_VIS_AREA_PXL) && (wr_y < V_VIS_AREA_PXL);
    assign accept   = wr_strobe && in_range && (state == WR_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= WR_IDLE;
            wr_reject <= 1'b0;
        end else begin
            // out of range, or a second write while one is held
            wr_reject <= wr_strobe && !accept;
            case (state)
                WR_IDLE:    if (accept) state <= WR_PENDING;
                WR_PENDING: if (grant == OWN_HOST) state <= WR_IDLE;
                default:    state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            host_addr <= FB_ADDR_BITS'(wr_y * H_VIS_AREA_PXL + wr_x);
            host_data <= wr_color;
        end
    end

    assign busy     = state == WR_PENDING;
    assign host_req = state == WR_PENDING;

endmodule

/* hdl/latency.sv */
module latency #(
    parameter int LENGTH = 1,
    parameter int WIDTH  = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    generate
        if (LENGTH == 0) begin : g_bypass
            assign out = in;
        end else begin : g_shift
            logic [WIDTH-1:0] stages [LENGTH];

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    for (int i = 0; i < LENGTH; i++) begin
                        stages[i] <= '0;
                    end
                end else begin
                    stages[0] <= in;
                    for (int i = 1; i < LENGTH; i++) begin
                        stages[i] <= stages[i-1];
                    end
                end
            end

            assign out = stages[LENGTH-1];
        end
    endgenerate

endmodule

/* hdl/vga.sv */
module vga #(
    parameter int H_VIS_AREA_PXL            = 800,
    parameter int H_FRONT_PORCH_PXL         = 40,
    parameter int H_SYNC_PULSE_PXL          = 128,
    parameter int H_BACK_PORCH_PXL          = 88,
    parameter int H_NUM_BITS                = 11,
    parameter int V_VIS_AREA_PXL            = 600,
    parameter int V_FRONT_PORCH_PXL         = 1,
    parameter int V_SYNC_PULSE_PXL          = 4,
    parameter int V_BACK_PORCH_PXL          = 23,
    parameter int V_NUM_BITS                = 10,
    parameter int CHANNEL_BITS              = 2,
    parameter int FB_ADDR_BITS              = 19,
    parameter int FRAME_BUFFER_READ_LATENCY = 2
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [video_pkg::NUM_CHANNELS*CHANNEL_BITS-1:0]   color,
    output logic                                              scan_req,
    output logic [FB_ADDR_BITS-1:0]                           scan_addr,
    output logic [video_pkg::OUT_CHANNEL_BITS-1:0]            red,
    output logic [video_pkg::OUT_CHANNEL_BITS-1:0]            green,
    output logic [video_pkg::OUT_CHANNEL_BITS-1:0]            blue,
    output logic                                              h_sync,
    output logic                                              v_sync
);
    import video_pkg::*;

    localparam int H_WHOLE_LINE_PXL = H_VIS_AREA_PXL + H_FRONT_PORCH_PXL
                                    + H_SYNC_PULSE_PXL + H_BACK_PORCH_PXL;
    localparam int V_WHOLE_FRAME_PXL = V_VIS_AREA_PXL + V_FRONT_PORCH_PXL
                                     + V_SYNC_PULSE_PXL + V_BACK_PORCH_PXL;
    localparam int H_SYNC_START = H_VIS_AREA_PXL + H_FRONT_PORCH_PXL;
    localparam int V_SYNC_START = V_VIS_AREA_PXL + V_FRONT_PORCH_PXL;

    logic [H_NUM_BITS-1:0] h_pxl_count;
    logic [V_NUM_BITS-1:0] v_pxl_count;
    logic [H_NUM_BITS-1:0] delayed_h_pxl_count;
    logic [V_NUM_BITS-1:0] delayed_v_pxl_count;
    logic                  h_counter_end;
    logic                  pxl_visible;
    logic [NUM_CHANNELS-1:0][OUT_CHANNEL_BITS-1:0] expanded;

    assign h_counter_end = h_pxl_count == H_NUM_BITS'(H_WHOLE_LINE_PXL - 1);

    counter #(
        .NUM_BITS(H_NUM_BITS)
    ) h_pxl_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .enable(1'b1),
        .last  (H_NUM_BITS'(H_WHOLE_LINE_PXL - 1)),
        .count (h_pxl_count)
    );

    // line count steps on the last pixel of each line
    counter #(
        .NUM_BITS(V_NUM_BITS)
    ) v_pxl_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .enable(h_counter_end),
        .last  (V_NUM_BITS'(V_WHOLE_FRAME_PXL - 1)),
        .count (v_pxl_count)
    );

    // one read per visible pixel, on the undelayed counts
    assign scan_req  = (h_pxl_count < H_VIS_AREA_PXL) && (v_pxl_count < V_VIS_AREA_PXL);
    assign scan_addr = FB_ADDR_BITS'(v_pxl_count * H_VIS_AREA_PXL + h_pxl_count);

    // align counts with the returning pixel data
    latency #(
        .LENGTH(FRAME_BUFFER_READ_LATENCY),
        .WIDTH (H_NUM_BITS + V_NUM_BITS)
    ) delay_pxl_count (
        .clk  (clk),
        .rst_n(rst_n),
        .in   ({h_pxl_count, v_pxl_count}),
        .out  ({delayed_h_pxl_count, delayed_v_pxl_count})
    );

    assign h_sync = !((delayed_h_pxl_count >= H_SYNC_START)
                   && (delayed_h_pxl_count < H_SYNC_START + H_SYNC_PULSE_PXL));
    assign v_sync = !((delayed_v_pxl_count >= V_SYNC_START)
                   && (delayed_v_pxl_count < V_SYNC_START + V_SYNC_PULSE_PXL));

    assign pxl_visible = (delayed_h_pxl_count < H_VIS_AREA_PXL)
                      && (delayed_v_pxl_count < V_VIS_AREA_PXL);

    // stored bits go to the top of each pin group, zeros below
    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_expand
        assign expanded[c] = pxl_visible
            ? {color[c*CHANNEL_BITS +: CHANNEL_BITS], {(OUT_CHANNEL_BITS-CHANNEL_BITS){1'b0}}}
            : '0;
    end

    assign red   = expanded[2];
    assign green = expanded[1];
    assign blue  = expanded[0];

    a_scan_addr_in_buffer: assert property (
        @(posedge clk) disable iff (!rst_n)
        scan_req |-> scan_addr < H_VIS_AREA_PXL * V_VIS_AREA_PXL
    );

endmodule

/* hdl/vga_subsystem.sv */
module vga_subsystem #(
    parameter int H_VIS_AREA_PXL            = 800,
    parameter int H_FRONT_PORCH_PXL         = 40,
    parameter int H_SYNC_PULSE_PXL          = 128,
    parameter int H_BACK_PORCH_PXL          = 88,
    parameter int H_NUM_BITS                = 11,
    parameter int V_VIS_AREA_PXL            = 600,
    parameter int V_FRONT_PORCH_PXL         = 1,
    parameter int V_SYNC_PULSE_PXL          = 4,
    parameter int V_BACK_PORCH_PXL          = 23,
    parameter int V_NUM_BITS                = 10,
    parameter int CHANNEL_BITS              = 2,
    parameter int FB_ADDR_BITS              = 19,
    // arbiter register plus memory register
    parameter int FRAME_BUFFER_READ_LATENCY = 2
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            wr_strobe,
    input  logic [H_NUM_BITS-1:0]                           wr_x,
    input  logic [V_NUM_BITS-1:0]                           wr_y,
    input  logic [video_pkg::NUM_CHANNELS*CHANNEL_BITS-1:0] wr_color,
    output logic                                            busy,
    output logic                                            wr_reject,
    output logic [video_pkg::OUT_CHANNEL_BITS-1:0]          red,
    output logic [video_pkg::OUT_CHANNEL_BITS-1:0]          green,
    output logic [video_pkg::OUT_CHANNEL_BITS-1:0]          blue,
    output logic                                            h_sync,
    output logic                                            v_sync
);
    import video_pkg::*;
    import fb_pkg::*;

    localparam int DATA_BITS = NUM_CHANNELS * CHANNEL_BITS;

    logic                    scan_req;
    logic [FB_ADDR_BITS-1:0] scan_addr;
    logic                    host_req;
    logic [FB_ADDR_BITS-1:0] host_addr;
    logic [DATA_BITS-1:0]    host_data;
    fb_owner_e               grant;
    logic                    mem_we;
    logic [FB_ADDR_BITS-1:0] mem_addr;
    logic [DATA_BITS-1:0]    mem_wdata;
    logic [DATA_BITS-1:0]    mem_rdata;

    vga #(
        .H_VIS_AREA_PXL           (H_VIS_AREA_PXL),
        .H_FRONT_PORCH_PXL        (H_FRONT_PORCH_PXL),
        .H_SYNC_PULSE_PXL         (H_SYNC_PULSE_PXL),
        .H_BACK_PORCH_PXL         (H_BACK_PORCH_PXL),
        .H_NUM_BITS               (H_NUM_BITS),
        .V_VIS_AREA_PXL           (V_VIS_AREA_PXL),
        .V_FRONT_PORCH_PXL        (V_FRONT_PORCH_PXL),
        .V_SYNC_PULSE_PXL         (V_SYNC_PULSE_PXL),
        .V_BACK_PORCH_PXL         (V_BACK_PORCH_PXL),
        .V_NUM_BITS               (V_NUM_BITS),
        .CHANNEL_BITS             (CHANNEL_BITS),
        .FB_ADDR_BITS             (FB_ADDR_BITS),
        .FRAME_BUFFER_READ_LATENCY(FRAME_BUFFER_READ_LATENCY)
    ) u_vga (
        .clk      (clk),
        .rst_n    (rst_n),
        .color    (mem_rdata),
        .scan_req (scan_req),
        .scan_addr(scan_addr),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .h_sync   (h_sync),
        .v_sync   (v_sync)
    );

    fb_arbiter #(
        .FB_ADDR_BITS(FB_ADDR_BITS),
        .DATA_BITS   (DATA_BITS)
    ) u_fb_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .scan_req (scan_req),
        .scan_addr(scan_addr),
        .host_req (host_req),
        .host_addr(host_addr),
        .host_data(host_data),
        .grant    (grant),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata)
    );

    frame_buffer #(
        .H_VIS_AREA_PXL(H_VIS_AREA_PXL),
        .V_VIS_AREA_PXL(V_VIS_AREA_PXL),
        .CHANNEL_BITS  (CHANNEL_BITS),
        .FB_ADDR_BITS  (FB_ADDR_BITS)
    ) u_frame_buffer (
        .clk      (clk),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    host_pixel_writer #(
        .H_VIS_AREA_PXL(H_VIS_AREA_PXL),
        .V_VIS_AREA_PXL(V_VIS_AREA_PXL),
        .H_NUM_BITS    (H_NUM_BITS),
        .V_NUM_BITS    (V_NUM_BITS),
        .CHANNEL_BITS  (CHANNEL_BITS),
        .FB_ADDR_BITS  (FB_ADDR_BITS)
    ) u_host_pixel_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_strobe(wr_strobe),
        .wr_x     (wr_x),
        .wr_y     (wr_y),
        .wr_color (wr_color),
        .grant    (grant),
        .busy     (busy),
        .wr_reject(wr_reject),
        .host_req (host_req),
        .host_addr(host_addr),
        .host_data(host_data)
    );

endmodule

/* hdl/video_pkg.sv */
package video_pkg;

    // bits per colour pin on the VGA connector
    localparam int OUT_CHANNEL_BITS = 4;

    // red, green, blue
    localparam int NUM_CHANNELS = 3;

endpackage

/* verification/tb_vga_subsystem.sv */
module tb_vga_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    import video_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int H_VIS        = 8;
    localparam int H_FP         = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BP         = 3;
    localparam int V_VIS        = 6;
    localparam int V_FP         = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BP         = 2;
    localparam int CH_BITS      = 2;
    localparam int H_TOTAL      = H_VIS + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = V_VIS + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int NUM_PIXELS   = H_VIS * V_VIS;
    localparam int DATA_BITS    = NUM_CHANNELS * CH_BITS;
    localparam int EXP_BITS     = 2 + NUM_CHANNELS * OUT_CHANNEL_BITS;
    // twelve frames of tests after reset
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 12 * FRAME_CYCLES;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        wr_strobe;
    logic [3:0]                  wr_x;
    logic [3:0]                  wr_y;
    logic [DATA_BITS-1:0]        wr_color;
    logic                        busy;
    logic                        wr_reject;
    logic [OUT_CHANNEL_BITS-1:0] red;
    logic [OUT_CHANNEL_BITS-1:0] green;
    logic [OUT_CHANNEL_BITS-1:0] blue;
    logic                        h_sync;
    logic                        v_sync;

    // scan counters and writer state as the model sees them
    int                   h_cnt;
    int                   v_cnt;
    int                   hd1;
    int                   vd1;
    int                   hd2;
    int                   vd2;
    logic                 m_pending;
    logic                 m_reject;
    logic                 m_commit;
    int                   p_addr;
    logic [DATA_BITS-1:0] p_color;
    logic [DATA_BITS-1:0] shadow [NUM_PIXELS];
    bit                   written [NUM_PIXELS];

    int     errors       = 0;
    int     color_checks = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycles       = 0;
    integer seed;

    vga_subsystem #(
        .H_VIS_AREA_PXL           (H_VIS),
        .H_FRONT_PORCH_PXL        (H_FP),
        .H_SYNC_PULSE_PXL         (H_SYNC),
        .H_BACK_PORCH_PXL         (H_BP),
        .H_NUM_BITS               (4),
        .V_VIS_AREA_PXL           (V_VIS),
        .V_FRONT_PORCH_PXL        (V_FP),
        .V_SYNC_PULSE_PXL         (V_SYNC),
        .V_BACK_PORCH_PXL         (V_BP),
        .V_NUM_BITS               (4),
        .CHANNEL_BITS             (CH_BITS),
        .FB_ADDR_BITS             (6),
        .FRAME_BUFFER_READ_LATENCY(2)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_strobe(wr_strobe),
        .wr_x     (wr_x),
        .wr_y     (wr_y),
        .wr_color (wr_color),
        .busy     (busy),
        .wr_reject(wr_reject),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .h_sync   (h_sync),
        .v_sync   (v_sync)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        logic in_range;
        logic on_screen;
        in_range  = wr_x < H_VIS && wr_y < V_VIS;
        on_screen = h_cnt < H_VIS && v_cnt < V_VIS;
        if (!rst_n) begin
            h_cnt     <= 0;
            v_cnt     <= 0;
            hd1       <= 0;
            vd1       <= 0;
            hd2       <= 0;
            vd2       <= 0;
            m_pending <= 1'b0;
            m_reject  <= 1'b0;
            m_commit  <= 1'b0;
        end else begin
            if (h_cnt == H_TOTAL - 1) begin
                h_cnt <= 0;
                v_cnt <= (v_cnt == V_TOTAL - 1) ? 0 : v_cnt + 1;
            end else begin
                h_cnt <= h_cnt + 1;
            end
            hd1      <= h_cnt;
            vd1      <= v_cnt;
            hd2      <= hd1;
            vd2      <= vd1;
            m_reject <= wr_strobe && !(in_range && !m_pending);
            // memory write lands one cycle after the grant
            if (m_commit) begin
                shadow[p_addr]  <= p_color;
                written[p_addr] <= 1'b1;
                m_commit        <= 1'b0;
            end
            if (!m_pending && wr_strobe && in_range) begin
                m_pending <= 1'b1;
                p_addr    <= int'(wr_y) * H_VIS + int'(wr_x);
                p_color   <= wr_color;
            end else if (m_pending && !on_screen) begin
                m_pending <= 1'b0;
                m_commit  <= 1'b1;
            end
        end
    end

    function automatic logic [EXP_BITS-1:0] expected_pixel(
        input int                   hd,
        input int                   vd,
        input logic [DATA_BITS-1:0] pixels [NUM_PIXELS]
    );
        logic                                   hs;
        logic                                   vs;
        logic [DATA_BITS-1:0]                   c;
        logic [NUM_CHANNELS*OUT_CHANNEL_BITS-1:0] rgb;
        hs  = !(hd >= H_VIS + H_FP && hd < H_VIS + H_FP + H_SYNC);
        vs  = !(vd >= V_VIS + V_FP && vd < V_VIS + V_FP + V_SYNC);
        rgb = '0;
        if (hd < H_VIS && vd < V_VIS) begin
            c   = pixels[vd * H_VIS + hd];
            // red sits in the top bits of the stored word
            rgb = {c[5:4], 2'b00, c[3:2], 2'b00, c[1:0], 2'b00};
        end
        return {hs, vs, rgb};
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Error [%0d ns] %s", $time, msg);
    endtask

    always @(negedge clk) begin
        logic [EXP_BITS-1:0] expected;
        logic                visible;
        logic                known;
        expected = expected_pixel(hd2, vd2, shadow);
        visible  = hd2 < H_VIS && vd2 < V_VIS;
        known    = !visible;
        if (visible) begin
            known = written[vd2 * H_VIS + hd2];
        end
        if (h_sync !== expected[EXP_BITS-1]) begin
            report_mismatch($sformatf("h_sync is %b, expected %b", h_sync, expected[EXP_BITS-1]));
        end
        if (v_sync !== expected[EXP_BITS-2]) begin
            report_mismatch($sformatf("v_sync is %b, expected %b", v_sync, expected[EXP_BITS-2]));
        end
        // pixels never written hold no defined colour
        if (known) begin
            if ({red, green, blue} !== expected[EXP_BITS-3:0]) begin
                report_mismatch($sformatf("rgb at (%0d,%0d) is %h, expected %h",
                                          hd2, vd2, {red, green, blue}, expected[EXP_BITS-3:0]));
            end
            if (visible) begin
                color_checks++;
            end
        end
        if (busy !== m_pending) begin
            report_mismatch($sformatf("busy is %b, expected %b", busy, m_pending));
        end
        if (wr_reject !== m_reject) begin
            report_mismatch($sformatf("wr_reject is %b, expected %b", wr_reject, m_reject));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [DATA_BITS-1:0] random_color();
        int r;
        r = $random(seed);
        return r[DATA_BITS-1:0];
    endfunction

    function automatic int random_below(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % n);
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_idle();
        while (busy) @(negedge clk);
    endtask

    // first delayed pixel of a frame, past the fill of the delay line
    task automatic wait_frame_start();
        while (!(hd2 == 0 && vd2 == 0 && hd1 == 1)) @(negedge clk);
    endtask

    task automatic wait_line_start();
        do @(negedge clk); while (!(h_cnt == 0 && v_cnt < V_VIS));
    endtask

    task automatic send_write(input int x, input int y, input logic [DATA_BITS-1:0] c,
                              output logic rejected);
        @(posedge clk);
        wr_strobe <= 1'b1;
        wr_x      <= 4'(x);
        wr_y      <= 4'(y);
        wr_color  <= c;
        @(posedge clk);
        wr_strobe <= 1'b0;
        @(negedge clk);
        rejected = wr_reject;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic check_h_sync();
        int   start_errors;
        int   lows;
        int   falls;
        int   misplaced;
        logic prev;
        start_errors = errors;
        lows         = 0;
        falls        = 0;
        misplaced    = 0;
        wait_frame_start();
        prev = h_sync;
        repeat (FRAME_CYCLES) begin
            if (!h_sync) lows++;
            if (prev && !h_sync) begin
                falls++;
                if (hd2 != H_VIS + H_FP) misplaced++;
            end
            prev = h_sync;
            @(negedge clk);
        end
        if (lows != H_SYNC * V_TOTAL) begin
            report_mismatch($sformatf("h_sync low for %0d cycles per frame", lows));
        end
        if (falls != V_TOTAL || misplaced != 0) begin
            report_mismatch($sformatf("%0d h_sync pulses, %0d misplaced", falls, misplaced));
        end
        finish_test("h_sync", start_errors);
    endtask

    task automatic check_v_sync_and_blanking();
        int start_errors;
        int lows;
        int stray;
        int lit;
        start_errors = errors;
        lows         = 0;
        stray        = 0;
        lit          = 0;
        wait_frame_start();
        repeat (FRAME_CYCLES) begin
            if (!v_sync) begin
                lows++;
                if (vd2 < V_VIS + V_FP || vd2 >= V_VIS + V_FP + V_SYNC) stray++;
            end
            if (!(hd2 < H_VIS && vd2 < V_VIS) && {red, green, blue} != '0) lit++;
            @(negedge clk);
        end
        if (lows != V_SYNC * H_TOTAL || stray != 0) begin
            report_mismatch($sformatf("v_sync low %0d cycles, %0d outside its lines", lows, stray));
        end
        if (lit != 0) begin
            report_mismatch($sformatf("%0d blanking cycles with colour", lit));
        end
        finish_test("v_sync_blanking", start_errors);
    endtask

    task automatic fill_frame();
        int   start_errors;
        int   checks_before;
        logic rejected;
        start_errors = errors;
        for (int i = 0; i < NUM_PIXELS; i++) begin
            wait_idle();
            send_write(i % H_VIS, i / H_VIS, random_color(), rejected);
            if (rejected) begin
                report_mismatch($sformatf("write to pixel %0d rejected", i));
            end
        end
        wait_idle();
        wait_frame_start();
        @(posedge clk);
        checks_before = color_checks;
        repeat (FRAME_CYCLES) @(negedge clk);
        @(posedge clk);
        if (color_checks - checks_before != NUM_PIXELS) begin
            report_mismatch($sformatf("only %0d pixels compared in the frame",
                                      color_checks - checks_before));
        end
        @(negedge clk);
        finish_test("full_frame_fill", start_errors);
    endtask

    task automatic write_in_visible();
        int   start_errors;
        int   held;
        logic rejected;
        start_errors = errors;
        held         = 0;
        wait_idle();
        wait_line_start();
        send_write(random_below(H_VIS), random_below(V_VIS), random_color(), rejected);
        if (rejected) begin
            report_mismatch("write during the visible area rejected");
        end
        while (busy) begin
            held++;
            @(negedge clk);
        end
        // accepted at pixel 2, so pixels 2 to the line end stay blocked
        if (held < H_VIS - 2) begin
            report_mismatch($sformatf("busy held only %0d cycles", held));
        end
        wait_cycles(FRAME_CYCLES + 4);
        finish_test("write_in_visible", start_errors);
    endtask

    task automatic reject_writes();
        int   start_errors;
        logic rejected;
        start_errors = errors;
        wait_idle();
        send_write(H_VIS + random_below(16 - H_VIS), random_below(V_VIS), random_color(), rejected);
        if (!rejected || busy) begin
            report_mismatch("x out of range not rejected cleanly");
        end
        send_write(random_below(H_VIS), V_VIS + random_below(16 - V_VIS), random_color(), rejected);
        if (!rejected || busy) begin
            report_mismatch("y out of range not rejected cleanly");
        end
        wait_line_start();
        send_write(random_below(H_VIS), random_below(V_VIS), random_color(), rejected);
        if (rejected) begin
            report_mismatch("valid write rejected");
        end
        send_write(random_below(H_VIS), random_below(V_VIS), random_color(), rejected);
        if (!rejected) begin
            report_mismatch("write while busy not rejected");
        end
        wait_idle();
        wait_cycles(FRAME_CYCLES + 4);
        finish_test("rejects", start_errors);
    endtask

    initial begin
        seed      = 32'hb32ffe9b;
        rst_n     = 1'b0;
        wr_strobe = 1'b0;
        wr_x      = '0;
        wr_y      = '0;
        wr_color  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_h_sync();
        check_v_sync_and_blanking();
        fill_frame();
        write_in_visible();
        reject_writes();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
